//--- dataPath.f
+incdir+verif
verilog/isaPkg.sv
verilog/dataPathPkg.sv
verilog/controlSequencer.sv
verilog/registerFile.sv
verilog/busHub.sv
verilog/aluUnit.sv
verilog/memoryUnit.sv
verilog/dataPath.sv
verif/dataPathTb.sv

//--- verif/cpuModel.svh
// Reference model state, instruction encoding and single-instruction execution
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

logic [dataPathPkg::DataWidth-1:0] modelRegs [dataPathPkg::RegCount];
logic [dataPathPkg::DataWidth-1:0] modelMem [dataPathPkg::MemDepth];

// Background word that differs at every address
function automatic logic [31:0] fillWord(input int address);
   logic [8:0] a;
   a = address[8:0];
   return {7'h2b, a, 7'h11, ~a};
endfunction

function automatic logic [31:0] extendImmediate(input logic [isaPkg::ImmWidth-1:0] field);
   return {{(32 - isaPkg::ImmWidth){field[isaPkg::ImmWidth-1]}}, field};
endfunction

function automatic logic [31:0] encodeInstruction(input logic [4:0] op, input logic [3:0] ra,
                                                  input logic [3:0] rb,
                                                  input logic [isaPkg::ImmWidth-1:0] field);
   logic [31:0] word;
   word = 32'(field);
   word[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb] = op;
   word[isaPkg::RaMsb:isaPkg::RaLsb] = ra;
   word[isaPkg::RbMsb:isaPkg::RbLsb] = rb;
   return word;
endfunction

task automatic resetModel();
   for (int i = 0; i < dataPathPkg::RegCount; i++) begin
      modelRegs[i] = '0;
   end
   for (int i = 0; i < dataPathPkg::MemDepth; i++) begin
      modelMem[i] = fillWord(i);
   end
endtask

task automatic stepModel(input logic [31:0] word);
   isaPkg::OpCode op;
   logic [3:0] ra;
   logic [3:0] rb;
   logic [3:0] rc;
   logic [31:0] a;
   logic [31:0] b;
   logic [31:0] imm;
   logic [31:0] address;
   op = isaPkg::OpCode'(word[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb]);
   ra = word[isaPkg::RaMsb:isaPkg::RaLsb];
   rb = word[isaPkg::RbMsb:isaPkg::RbLsb];
   rc = word[isaPkg::RcMsb:isaPkg::RcLsb];
   imm = extendImmediate(word[isaPkg::ImmWidth-1:0]);
   // Rb is a base field, so R0 there reads as zero
   a = (rb == 4'd0) ? 32'd0 : modelRegs[rb];
   b = modelRegs[rc];
   address = a + imm;
   case (op)
      isaPkg::OpAdd: modelRegs[ra] = a + b;
      isaPkg::OpSub: modelRegs[ra] = a - b;
      isaPkg::OpAnd: modelRegs[ra] = a & b;
      isaPkg::OpOr: modelRegs[ra] = a | b;
      isaPkg::OpMul: modelRegs[ra] = a * b;
      isaPkg::OpAddi: modelRegs[ra] = a + imm;
      isaPkg::OpAndi: modelRegs[ra] = a & imm;
      isaPkg::OpOri: modelRegs[ra] = a | imm;
      isaPkg::OpLd: modelRegs[ra] = modelMem[address[8:0]];
      isaPkg::OpSt: modelMem[address[8:0]] = modelRegs[ra];
      default: ;
   endcase
endtask

`endif

//--- verif/dataPathTb.sv
// Testbench for the processor datapath with random programs and a reference model
`timescale 1ns/1ps
`default_nettype none

module dataPathTb;

   localparam int RunLimit = 5000;
   localparam int ProgramMax = 64;

   logic Clock;
   logic reset;
   logic run;
   logic hostWrite;
   logic [dataPathPkg::AddrWidth-1:0] hostAddress;
   logic [dataPathPkg::DataWidth-1:0] hostData;
   logic [dataPathPkg::DataWidth-1:0] hostReadData;
   logic [dataPathPkg::RegIndexWidth-1:0] debugSelect;
   logic [dataPathPkg::DataWidth-1:0] debugData;
   logic instructionDone;
   logic halted;

   logic [31:0] programWords [ProgramMax];
   int doneCycle [ProgramMax];
   int progLen;
   int doneCount;
   int errorCount;
   int testStartErrors;
   int testsPassed;
   int testsFailed;

   `include "cpuModel.svh"

   dataPath u_dut (
      .Clock, .reset, .run, .hostWrite, .hostAddress, .hostData, .hostReadData,
      .debugSelect, .debugData, .instructionDone, .halted
   );

   initial begin
      Clock = 1'b0;
      forever #50 Clock = ~Clock;
   end

   task automatic startProgram();
      resetModel();
      progLen = 0;
      testStartErrors = errorCount;
   endtask

   // Each instruction also runs on the model as it is generated
   task automatic appendInstruction(input logic [31:0] word);
      programWords[progLen] = word;
      progLen++;
      stepModel(word);
   endtask

   task automatic seedRegister();
      appendInstruction(encodeInstruction(isaPkg::OpAddi, 4'(1 + $urandom % 15), 4'd0,
                                          19'($urandom)));
   endtask

   task automatic randomImmOp();
      appendInstruction(encodeInstruction(5'(isaPkg::OpAddi + $urandom % 3),
                                          4'(1 + $urandom % 15), 4'($urandom),
                                          19'($urandom)));
   endtask

   task automatic randomRegOp(input bit withMul, input bit baseZero);
      logic [4:0] op;
      logic [3:0] rb;
      op = 5'($urandom % (withMul ? 5 : 4));
      rb = baseZero ? 4'd0 : 4'($urandom);
      appendInstruction(encodeInstruction(op, 4'(1 + $urandom % 15), rb,
                                          {4'($urandom), 15'd0}));
   endtask

   // Offset chosen so the base plus offset lands in the upper half of memory
   task automatic storeLoadPair();
      logic [3:0] rb;
      logic [31:0] base;
      logic [8:0] target;
      logic [8:0] offset;
      rb = 4'($urandom);
      base = (rb == 4'd0) ? 32'd0 : modelRegs[rb];
      target = 9'(256 + $urandom % 256);
      offset = target - base[8:0];
      appendInstruction(encodeInstruction(isaPkg::OpSt, 4'($urandom), rb, {10'd0, offset}));
      appendInstruction(encodeInstruction(isaPkg::OpLd, 4'(1 + $urandom % 15), rb,
                                          {10'd0, offset}));
   endtask

   task automatic applyReset();
      @(negedge Clock);
      reset = 1'b1;
      run = 1'b0;
      hostWrite = 1'b0;
      repeat (4) @(negedge Clock);
      if (instructionDone !== 1'b0 || halted !== 1'b0) begin
         $display("Fail %0t instructionDone or halted not low after reset", $time);
         errorCount++;
      end
      reset = 1'b0;
   endtask

   task automatic loadMemory();
      for (int i = 0; i < dataPathPkg::MemDepth; i++) begin
         @(negedge Clock);
         hostWrite = 1'b1;
         hostAddress = 9'(i);
         hostData = (i < progLen) ? programWords[i] : fillWord(i);
      end
      @(negedge Clock);
      hostWrite = 1'b0;
   endtask

   // Starts the program and stops it with a reset after two instructions
   task automatic interruptRun();
      int cycles;
      int seen;
      applyReset();
      loadMemory();
      @(negedge Clock);
      run = 1'b1;
      cycles = 0;
      seen = 0;
      while (seen < 2 && cycles < RunLimit) begin
         @(negedge Clock);
         cycles++;
         if (instructionDone) seen++;
      end
      if (seen < 2) begin
         $display("Fail %0t two instructions did not complete before the reset", $time);
         errorCount++;
      end
   endtask

   task automatic checkLatency();
      int interval;
      int minMul;
      int maxAlu;
      logic [4:0] op;
      minMul = RunLimit;
      maxAlu = 0;
      for (int i = 0; i < doneCount && i < progLen; i++) begin
         interval = doneCycle[i] - ((i == 0) ? 0 : doneCycle[i-1]);
         op = programWords[i][isaPkg::OpcodeMsb:isaPkg::OpcodeLsb];
         if (op == isaPkg::OpMul && interval < minMul) minMul = interval;
         else if (op != isaPkg::OpMul && op <= isaPkg::OpOri && interval > maxAlu)
            maxAlu = interval;
      end
      if (minMul <= maxAlu) begin
         $display("Fail %0t multiply took %0d cycles, not more than the %0d of other ops",
                  $time, minMul, maxAlu);
         errorCount++;
      end
   endtask

   task automatic executeProgram(input string name, input bit withLatency);
      int cycles;
      logic [31:0] expected;
      applyReset();
      loadMemory();
      @(negedge Clock);
      run = 1'b1;
      cycles = 0;
      doneCount = 0;
      while (!halted && cycles < RunLimit) begin
         @(negedge Clock);
         cycles++;
         if (instructionDone) begin
            if (doneCount < ProgramMax) doneCycle[doneCount] = cycles;
            doneCount++;
         end
      end
      if (!halted) begin
         $display("Fail %0t halted did not rise within %0d cycles", $time, RunLimit);
         errorCount++;
      end
      if (doneCount != progLen - 1) begin
         $display("Fail %0t instructionDone count got %0d expected %0d",
                  $time, doneCount, progLen - 1);
         errorCount++;
      end
      if (withLatency) checkLatency();
      // Nothing may move once halted
      repeat (10) begin
         @(negedge Clock);
         if (halted !== 1'b1 || instructionDone !== 1'b0) begin
            $display("Fail %0t halted dropped or instructionDone pulsed after halt", $time);
            errorCount++;
         end
      end
      for (int i = 0; i < dataPathPkg::RegCount; i++) begin
         @(negedge Clock);
         debugSelect = 4'(i);
         @(posedge Clock);
         if (debugData !== modelRegs[i]) begin
            $display("Fail %0t debugData[%0d] got %h expected %h",
                     $time, i, debugData, modelRegs[i]);
            errorCount++;
         end
      end
      @(negedge Clock);
      run = 1'b0;
      for (int i = 0; i < dataPathPkg::MemDepth; i++) begin
         @(negedge Clock);
         hostAddress = 9'(i);
         expected = (i < progLen) ? programWords[i] : modelMem[i];
         @(posedge Clock);
         if (hostReadData !== expected) begin
            $display("Fail %0t hostReadData[%0d] got %h expected %h",
                     $time, i, hostReadData, expected);
            errorCount++;
         end
      end
      if (errorCount == testStartErrors) begin
         testsPassed++;
         $display("Test %s passed", name);
      end else begin
         testsFailed++;
         $display("Test %s failed with %0d errors", name, errorCount - testStartErrors);
      end
   endtask

   initial begin
      reset = 1'b1;
      run = 1'b0;
      hostWrite = 1'b0;
      hostAddress = '0;
      hostData = '0;
      debugSelect = '0;
      errorCount = 0;
      testsPassed = 0;
      testsFailed = 0;
      void'($urandom(32'hd6bb_8490));

      startProgram();
      repeat (8) seedRegister();
      repeat (12) randomImmOp();
      appendInstruction(encodeInstruction(isaPkg::OpHalt, 4'd0, 4'd0, 19'd0));
      executeProgram("immediate operations", 1'b0);

      startProgram();
      repeat (6) seedRegister();
      // A nonzero R0 shows that R0 as a base still reads as zero
      appendInstruction(encodeInstruction(isaPkg::OpAddi, 4'd0, 4'd0,
                                          19'(1 + $urandom % 4096)));
      randomRegOp(1'b0, 1'b1);
      repeat (14) randomRegOp(1'b0, 1'b0);
      appendInstruction(encodeInstruction(isaPkg::OpHalt, 4'd0, 4'd0, 19'd0));
      executeProgram("register operations", 1'b0);

      startProgram();
      repeat (6) seedRegister();
      repeat (4) begin
         randomRegOp(1'b0, 1'b0);
         appendInstruction(encodeInstruction(isaPkg::OpMul, 4'(1 + $urandom % 15),
                                             4'($urandom), {4'($urandom), 15'd0}));
      end
      appendInstruction(encodeInstruction(isaPkg::OpHalt, 4'd0, 4'd0, 19'd0));
      executeProgram("multiply", 1'b1);

      startProgram();
      repeat (6) seedRegister();
      repeat (6) begin
         storeLoadPair();
         randomImmOp();
      end
      appendInstruction(encodeInstruction(isaPkg::OpHalt, 4'd0, 4'd0, 19'd0));
      executeProgram("memory", 1'b0);

      // Mixed program for the instruction count and the halt behavior
      startProgram();
      repeat (4) seedRegister();
      repeat (12) begin
         case ($urandom % 3)
            0: randomImmOp();
            1: randomRegOp(1'b1, 1'b0);
            default: storeLoadPair();
         endcase
      end
      appendInstruction(encodeInstruction(isaPkg::OpHalt, 4'd0, 4'd0, 19'd0));
      executeProgram("instruction count and halt", 1'b1);

      startProgram();
      repeat (5) seedRegister();
      repeat (4) randomRegOp(1'b0, 1'b0);
      storeLoadPair();
      appendInstruction(encodeInstruction(isaPkg::OpHalt, 4'd0, 4'd0, 19'd0));
      interruptRun();
      executeProgram("reset restart", 1'b0);

      $display("Tests passed %0d, failed %0d, errors %0d", testsPassed, testsFailed, errorCount);
      if (errorCount == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- verilog/aluUnit.sv
// Single-cycle add, sub, and, or with a shift-add multiplier and the RZ register
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
   input  wire logic                              Clock,
   input  wire logic                              reset,
   input  var  isaPkg::AluOp                      aluOp,
   input  wire logic [dataPathPkg::DataWidth-1:0] ryData,
   input  wire logic [dataPathPkg::DataWidth-1:0] busData,
   input  wire logic                              start,
   input  wire logic                              RZin,
   output logic      [dataPathPkg::DataWidth-1:0] rzData,
   output logic                                   finished
);

   localparam int CountWidth = $clog2(dataPathPkg::DataWidth + 1);

   logic [dataPathPkg::DataWidth-1:0] quickResult;
   logic [dataPathPkg::DataWidth-1:0] product;
   logic [dataPathPkg::DataWidth-1:0] multiplicand;
   logic [dataPathPkg::DataWidth-1:0] multiplier;
   logic [dataPathPkg::DataWidth-1:0] partial;
   logic [CountWidth-1:0] stepCount;
   logic isMul;

   assign isMul = (aluOp == isaPkg::AluMul);
   assign partial = product + (multiplier[0] ? multiplicand : '0);

   always_comb begin
      case (aluOp)
         isaPkg::AluSub: quickResult = ryData - busData;
         isaPkg::AluAnd: quickResult = ryData & busData;
         isaPkg::AluOr: quickResult = ryData | busData;
         default: quickResult = ryData + busData;
      endcase
   end

   // One multiplier bit per cycle, finished after the last one
   always_ff @(posedge Clock) begin
      if (reset) begin
         stepCount <= '0;
         finished <= 1'b0;
      end else begin
         finished <= (start && !isMul) || (stepCount == CountWidth'(1));
         if (start && isMul) stepCount <= CountWidth'(dataPathPkg::DataWidth);
         else if (stepCount != '0) stepCount <= stepCount - 1'b1;
      end
   end

   always_ff @(posedge Clock) begin
      if (start) begin
         product <= '0;
         multiplicand <= ryData;
         multiplier <= busData;
      end else if (stepCount != '0) begin
         product <= partial;
         multiplicand <= multiplicand << 1;
         multiplier <= multiplier >> 1;
      end
   end

   always_ff @(posedge Clock) begin
      if (RZin && start && !isMul) rzData <= quickResult;
      else if (RZin && stepCount == CountWidth'(1)) rzData <= partial;
   end

   // The sequencer never restarts the ALU during a multiply
   startWhileIdle: assert property (@(posedge Clock) disable iff (reset)
      start |-> (stepCount == '0));

endmodule

`default_nettype wire

//--- verilog/busHub.sv
// PC, IR and RY registers, immediate extension, register index decode and bus mux
`timescale 1ns/1ps
`default_nettype none

module busHub (
   input  wire logic                                  Clock,
   input  wire logic                                  reset,
   input  wire logic                                  PCin, IncPC, IRin, RYin,
   input  wire logic                                  Gra, Grb, Grc,
   input  wire logic                                  RFout, PCout, MDRout, RZout, Immout,
   input  wire logic [dataPathPkg::DataWidth-1:0]     regData,
   input  wire logic [dataPathPkg::DataWidth-1:0]     mdrData,
   input  wire logic [dataPathPkg::DataWidth-1:0]     rzData,
   output logic      [dataPathPkg::DataWidth-1:0]     busData,
   output logic      [dataPathPkg::RegIndexWidth-1:0] regIndex,
   output logic      [dataPathPkg::DataWidth-1:0]     ir,
   output logic      [dataPathPkg::DataWidth-1:0]     ryData,
   output logic      [dataPathPkg::DataWidth-1:0]     pc
);

   localparam int ExtendBits = dataPathPkg::DataWidth - isaPkg::ImmWidth;

   dataPathPkg::BusSource source;
   logic [dataPathPkg::DataWidth-1:0] immData;

   assign immData = {{ExtendBits{ir[isaPkg::ImmWidth-1]}}, ir[isaPkg::ImmWidth-1:0]};

   always_comb begin
      regIndex = '0;
      if (Gra) regIndex = ir[isaPkg::RaMsb:isaPkg::RaLsb];
      else if (Grb) regIndex = ir[isaPkg::RbMsb:isaPkg::RbLsb];
      else if (Grc) regIndex = ir[isaPkg::RcMsb:isaPkg::RcLsb];
   end

   // With no select active the register path wins and carries zero
   always_comb begin
      source = dataPathPkg::BusRf;
      if (PCout) source = dataPathPkg::BusPc;
      else if (MDRout) source = dataPathPkg::BusMdr;
      else if (RZout) source = dataPathPkg::BusRz;
      else if (Immout) source = dataPathPkg::BusImm;
   end

   always_comb begin
      case (source)
         dataPathPkg::BusPc: busData = pc;
         dataPathPkg::BusMdr: busData = mdrData;
         dataPathPkg::BusRz: busData = rzData;
         dataPathPkg::BusImm: busData = immData;
         default: busData = RFout ? regData : '0;
      endcase
   end

   always_ff @(posedge Clock) begin
      if (reset) pc <= '0;
      else if (PCin) pc <= busData;
      else if (IncPC) pc <= pc + 1'b1;
   end

   always_ff @(posedge Clock) begin
      if (IRin) ir <= busData;
      if (RYin) ryData <= busData;
   end

   busSelectOneHot: assert property (@(posedge Clock) disable iff (reset)
      $onehot0({RFout, PCout, MDRout, RZout, Immout}));

endmodule

`default_nettype wire

//--- verilog/controlSequencer.sv
// Fetch, decode and execute step machine that drives all datapath strobes
`timescale 1ns/1ps
`default_nettype none

module controlSequencer (
   input  wire logic                              Clock,
   input  wire logic                              reset,
   input  wire logic                              run,
   input  wire logic [dataPathPkg::DataWidth-1:0] ir,
   input  wire logic                              finished,
   input  wire logic                              memFinished,
   output logic                                   RFout, PCout, MDRout, RZout, Immout,
   output logic                                   PCin, IncPC, IRin, RYin, RZin,
   output logic                                   MARin, MDRin, Rin, Rout,
   output logic                                   Gra, Grb, Grc, BAout,
   output logic                                   Read, Write, start,
   output isaPkg::AluOp                           aluOp,
   output logic                                   instructionDone,
   output logic                                   halted
);

   dataPathPkg::Step step;
   isaPkg::OpCode opcode;
   logic pending;
   logic waitStep;
   logic awaited;
   logic immOperand;
   logic isHalt;
   logic isLoad;
   logic isStore;

   assign opcode = isaPkg::OpCode'(ir[isaPkg::OpcodeMsb:isaPkg::OpcodeLsb]);
   assign isLoad = (opcode == isaPkg::OpLd);
   assign isStore = (opcode == isaPkg::OpSt);
   assign instructionDone = (step == dataPathPkg::T7);
   assign halted = (step == dataPathPkg::Halt);

   // Opcode to ALU operation and second operand source
   always_comb begin
      aluOp = isaPkg::AluAdd;
      immOperand = 1'b0;
      isHalt = 1'b0;
      case (opcode)
         isaPkg::OpAdd: aluOp = isaPkg::AluAdd;
         isaPkg::OpSub: aluOp = isaPkg::AluSub;
         isaPkg::OpAnd: aluOp = isaPkg::AluAnd;
         isaPkg::OpOr: aluOp = isaPkg::AluOr;
         isaPkg::OpMul: aluOp = isaPkg::AluMul;
         isaPkg::OpAddi, isaPkg::OpLd, isaPkg::OpSt: immOperand = 1'b1;
         isaPkg::OpAndi: begin
            aluOp = isaPkg::AluAnd;
            immOperand = 1'b1;
         end
         isaPkg::OpOri: begin
            aluOp = isaPkg::AluOr;
            immOperand = 1'b1;
         end
         // Unassigned codes stop the machine as halt does
         default: isHalt = 1'b1;
      endcase
   end

   // Steps that hold until the memory or the ALU answers
   always_comb begin
      waitStep = 1'b0;
      awaited = 1'b0;
      case (step)
         dataPathPkg::T1: begin
            waitStep = 1'b1;
            awaited = memFinished;
         end
         dataPathPkg::T4: begin
            waitStep = 1'b1;
            awaited = finished;
         end
         dataPathPkg::T5: begin
            waitStep = isLoad;
            awaited = isLoad && memFinished;
         end
         dataPathPkg::T6: begin
            waitStep = isStore;
            awaited = isStore && memFinished;
         end
         default: ;
      endcase
   end

   always_ff @(posedge Clock) begin
      if (reset) begin
         step <= dataPathPkg::Idle;
         pending <= 1'b0;
      end else begin
         // Request strobes go out only in the first cycle of a wait
         pending <= waitStep && !awaited;
         case (step)
            dataPathPkg::Idle: if (run) step <= dataPathPkg::T0;
            dataPathPkg::T0: step <= dataPathPkg::T1;
            dataPathPkg::T1: if (memFinished) step <= dataPathPkg::T2;
            dataPathPkg::T2: step <= dataPathPkg::T3;
            dataPathPkg::T3: step <= isHalt ? dataPathPkg::Halt : dataPathPkg::T4;
            dataPathPkg::T4: if (finished) step <= dataPathPkg::T5;
            dataPathPkg::T5: begin
               if (isStore || (isLoad && memFinished)) step <= dataPathPkg::T6;
               else if (!isLoad) step <= dataPathPkg::T7;
            end
            dataPathPkg::T6: if (!isStore || memFinished) step <= dataPathPkg::T7;
            dataPathPkg::T7: step <= run ? dataPathPkg::T0 : dataPathPkg::Idle;
            default: step <= dataPathPkg::Halt;
         endcase
      end
   end

   always_comb begin
      {PCout, MDRout, RZout, Immout} = '0;
      {PCin, IncPC, IRin, RYin, RZin, MARin, MDRin, Rin, Rout} = '0;
      {Gra, Grb, Grc, BAout, Read, Write, start} = '0;
      case (step)
         dataPathPkg::T0: {MARin, PCout, IncPC} = 3'b111;
         dataPathPkg::T1: Read = !pending;
         dataPathPkg::T2: {MDRout, IRin} = 2'b11;
         dataPathPkg::T3: if (!isHalt) {Rout, Grb, BAout, RYin} = 4'b1111;
         dataPathPkg::T4: begin
            if (immOperand) Immout = 1'b1;
            else {Rout, Grc} = 2'b11;
            RZin = 1'b1;
            start = !pending;
         end
         dataPathPkg::T5: begin
            if (isLoad) begin
               RZout = 1'b1;
               MARin = !pending;
               Read = !pending;
            end else if (isStore) begin
               {Rout, Gra, MDRin} = 3'b111;
            end else begin
               {RZout, Gra, Rin} = 3'b111;
            end
         end
         dataPathPkg::T6: begin
            if (isLoad) begin
               {MDRout, Gra, Rin} = 3'b111;
            end else begin
               RZout = 1'b1;
               MARin = !pending;
               Write = !pending;
            end
         end
         default: ;
      endcase
   end

   // Register read port and bus select always move together
   assign RFout = Rout;

   startReadExclusive: assert property (@(posedge Clock) disable iff (reset)
      !(start && Read));
   writeOnlyInStore: assert property (@(posedge Clock) disable iff (reset)
      Write |-> (isStore && step == dataPathPkg::T6));

endmodule

`default_nettype wire

//--- verilog/dataPath.sv
// Processor top level connecting sequencer, register file, bus hub, ALU and memory
`timescale 1ns/1ps
`default_nettype none

module dataPath (
   input  wire logic                                  Clock,
   input  wire logic                                  reset,
   input  wire logic                                  run,
   input  wire logic                                  hostWrite,
   input  wire logic [dataPathPkg::AddrWidth-1:0]     hostAddress,
   input  wire logic [dataPathPkg::DataWidth-1:0]     hostData,
   output logic      [dataPathPkg::DataWidth-1:0]     hostReadData,
   input  wire logic [dataPathPkg::RegIndexWidth-1:0] debugSelect,
   output logic      [dataPathPkg::DataWidth-1:0]     debugData,
   output logic                                       instructionDone,
   output logic                                       halted
);

   logic [dataPathPkg::DataWidth-1:0] busData;
   logic [dataPathPkg::DataWidth-1:0] ir;
   logic [dataPathPkg::DataWidth-1:0] ryData;
   logic [dataPathPkg::DataWidth-1:0] regData;
   logic [dataPathPkg::DataWidth-1:0] mdrData;
   logic [dataPathPkg::DataWidth-1:0] rzData;
   logic [dataPathPkg::RegIndexWidth-1:0] regIndex;
   isaPkg::AluOp aluOp;
   logic RFout, PCout, MDRout, RZout, Immout;
   logic PCin, IncPC, IRin, RYin, RZin, MARin, MDRin, Rin, Rout;
   logic Gra, Grb, Grc, BAout, Read, Write, start;
   logic finished, memFinished;

   controlSequencer u_sequencer (
      .Clock, .reset, .run, .ir, .finished, .memFinished,
      .RFout, .PCout, .MDRout, .RZout, .Immout,
      .PCin, .IncPC, .IRin, .RYin, .RZin, .MARin, .MDRin, .Rin, .Rout,
      .Gra, .Grb, .Grc, .BAout, .Read, .Write, .start, .aluOp,
      .instructionDone, .halted
   );

   registerFile u_registers (
      .Clock, .reset, .busData, .regIndex, .Rin, .Rout, .BAout,
      .debugSelect, .regData, .debugData
   );

   // PC stays internal since nothing outside reads it
   busHub u_busHub (
      .Clock, .reset, .PCin, .IncPC, .IRin, .RYin, .Gra, .Grb, .Grc,
      .RFout, .PCout, .MDRout, .RZout, .Immout,
      .regData, .mdrData, .rzData, .busData, .regIndex, .ir, .ryData, .pc()
   );

   aluUnit u_alu (
      .Clock, .reset, .aluOp, .ryData, .busData, .start, .RZin, .rzData, .finished
   );

   memoryUnit u_memory (
      .Clock, .reset, .MARin, .MDRin, .MDRout, .Read, .Write, .busData, .run,
      .hostWrite, .hostAddress, .hostData, .mdrData, .memFinished, .hostReadData
   );

endmodule

`default_nettype wire

//--- verilog/dataPathPkg.sv
// Datapath sizes, memory latency, bus source codes and sequencer step encoding
`default_nettype none

package dataPathPkg;

   localparam int DataWidth = 32;
   localparam int RegCount = 16;
   localparam int RegIndexWidth = $clog2(RegCount);
   localparam int MemDepth = 512;
   localparam int AddrWidth = 9;
   // Cycles from a sampled Read or Write to memFinished
   localparam int MemLatency = 2;

   typedef enum logic [2:0] {
      BusRf  = 3'd0,
      BusPc  = 3'd1,
      BusMdr = 3'd2,
      BusRz  = 3'd3,
      BusImm = 3'd4
   } BusSource;

   // T7 is the completion step that carries instructionDone
   typedef enum logic [3:0] {
      Idle = 4'd0,
      T0   = 4'd1,
      T1   = 4'd2,
      T2   = 4'd3,
      T3   = 4'd4,
      T4   = 4'd5,
      T5   = 4'd6,
      T6   = 4'd7,
      T7   = 4'd8,
      Halt = 4'd9
   } Step;

endpackage

`default_nettype wire

//--- verilog/isaPkg.sv
// Instruction field positions, opcode encoding and ALU operation codes
`default_nettype none

package isaPkg;

   // Field positions inside a 32-bit instruction word
   localparam int OpcodeMsb = 31;
   localparam int OpcodeLsb = 27;
   localparam int RaMsb = 26;
   localparam int RaLsb = 23;
   localparam int RbMsb = 22;
   localparam int RbLsb = 19;
   localparam int RcMsb = 18;
   localparam int RcLsb = 15;
   localparam int ImmWidth = 19;

   typedef enum logic [4:0] {
      OpAdd  = 5'd0,
      OpSub  = 5'd1,
      OpAnd  = 5'd2,
      OpOr   = 5'd3,
      OpMul  = 5'd4,
      OpAddi = 5'd5,
      OpAndi = 5'd6,
      OpOri  = 5'd7,
      OpLd   = 5'd8,
      OpSt   = 5'd9,
      OpHalt = 5'd10
   } OpCode;

   // Operation select seen by the ALU
   typedef enum logic [2:0] {
      AluAdd = 3'd0,
      AluSub = 3'd1,
      AluAnd = 3'd2,
      AluOr  = 3'd3,
      AluMul = 3'd4
   } AluOp;

endpackage

`default_nettype wire

//--- verilog/memoryUnit.sv
// MAR, MDR and word memory with fixed-latency access and a host load port
`timescale 1ns/1ps
`default_nettype none

module memoryUnit (
   input  wire logic                              Clock,
   input  wire logic                              reset,
   input  wire logic                              MARin, MDRin, MDRout,
   input  wire logic                              Read, Write,
   input  wire logic [dataPathPkg::DataWidth-1:0] busData,
   input  wire logic                              run,
   input  wire logic                              hostWrite,
   input  wire logic [dataPathPkg::AddrWidth-1:0] hostAddress,
   input  wire logic [dataPathPkg::DataWidth-1:0] hostData,
   output logic      [dataPathPkg::DataWidth-1:0] mdrData,
   output logic                                   memFinished,
   output logic      [dataPathPkg::DataWidth-1:0] hostReadData
);

   localparam int CountWidth = $clog2(dataPathPkg::MemLatency + 1);

   logic [dataPathPkg::DataWidth-1:0] memory [dataPathPkg::MemDepth];
   logic [dataPathPkg::AddrWidth-1:0] mar;
   logic [CountWidth-1:0] latencyCount;
   logic writeAccess;

   assign memFinished = (latencyCount == CountWidth'(1));
   assign hostReadData = run ? '0 : memory[hostAddress];

   always_ff @(posedge Clock) begin
      if (reset) begin
         latencyCount <= '0;
         writeAccess <= 1'b0;
      end else if ((Read || Write) && latencyCount == '0) begin
         latencyCount <= CountWidth'(dataPathPkg::MemLatency);
         writeAccess <= Write;
      end else if (latencyCount != '0) begin
         latencyCount <= latencyCount - 1'b1;
      end
   end

   // Address and data are taken when the access completes
   always_ff @(posedge Clock) begin
      if (MARin) mar <= busData[dataPathPkg::AddrWidth-1:0];
      if (memFinished && !writeAccess) mdrData <= memory[mar];
      else if (MDRin) mdrData <= busData;
   end

   always_ff @(posedge Clock) begin
      if (!run && hostWrite) memory[hostAddress] <= hostData;
      else if (memFinished && writeAccess) memory[mar] <= mdrData;
   end

   mdrStableOnBus: assert property (@(posedge Clock) disable iff (reset)
      MDRout |-> (latencyCount == '0));

endmodule

`default_nettype wire

//--- verilog/registerFile.sv
// Sixteen-entry register file with field selection and R0 base addressing
`timescale 1ns/1ps
`default_nettype none

module registerFile (
   input  wire logic [dataPathPkg::DataWidth-1:0]     busData,
   input  wire logic                                  Clock,
   input  wire logic                                  reset,
   input  wire logic [dataPathPkg::RegIndexWidth-1:0] regIndex,
   input  wire logic                                  Rin,
   input  wire logic                                  Rout,
   input  wire logic                                  BAout,
   input  wire logic [dataPathPkg::RegIndexWidth-1:0] debugSelect,
   output logic      [dataPathPkg::DataWidth-1:0]     regData,
   output logic      [dataPathPkg::DataWidth-1:0]     debugData
);

   logic [dataPathPkg::DataWidth-1:0] regs [dataPathPkg::RegCount];
   logic baseZero;

   // R0 reads as zero when it serves as a base register
   assign baseZero = BAout && (regIndex == '0);
   assign regData = (Rout && !baseZero) ? regs[regIndex] : '0;
   assign debugData = regs[debugSelect];

   always_ff @(posedge Clock) begin
      if (reset) begin
         for (int i = 0; i < dataPathPkg::RegCount; i++) begin
            regs[i] <= '0;
         end
      end else if (Rin) begin
         regs[regIndex] <= busData;
      end
   end

   rinRoutExclusive: assert property (@(posedge Clock) disable iff (reset)
      !(Rin && Rout));

endmodule

`default_nettype wire
